/* Bender.yml */
package:
  name: router

sources:
  - rtl/router_frame_pkg.sv
  - rtl/router_arb_pkg.sv
  - rtl/router_input_port.sv
  - rtl/router_output_arbiter.sv
  - rtl/router_crossbar.sv
  - rtl/router.sv
  - target: simulation
    files:
      - sim/router_tb.sv

/* project.f */
rtl/router_frame_pkg.sv
rtl/router_arb_pkg.sv
rtl/router_input_port.sv
rtl/router_output_arbiter.sv
rtl/router_crossbar.sv
rtl/router.sv
sim/router_tb.sv

/* rtl/router.sv */
`default_nettype none

module router (
  input  logic                               io,
  input  logic                               reset_n,
  input  router_frame_pkg::port_mask_t       din,
  input  router_frame_pkg::port_mask_t       frame_n,
  input  router_frame_pkg::port_mask_t       valid_n,
  output router_frame_pkg::port_mask_t       dout,
  output router_frame_pkg::port_mask_t       frameo_n,
  output router_frame_pkg::port_mask_t       valido_n,
  output wire router_frame_pkg::port_mask_t  busy_n
);

  // rows are indexed by the driving module, columns by the receiving one
  wire router_frame_pkg::port_mask_t req_row [router_frame_pkg::num_ports];
  wire router_frame_pkg::port_mask_t req_col [router_frame_pkg::num_ports];
  wire router_frame_pkg::port_mask_t gnt_row [router_frame_pkg::num_ports];
  wire router_frame_pkg::port_mask_t gnt_col [router_frame_pkg::num_ports];
  wire router_frame_pkg::port_idx_t  dest [router_frame_pkg::num_ports];
  wire router_frame_pkg::port_idx_t  src [router_frame_pkg::num_ports];
  wire router_frame_pkg::port_mask_t deassert;
  wire router_frame_pkg::port_mask_t src_frame_n;

  for (genvar i = 0; i < router_frame_pkg::num_ports; i++) begin : g_port
    router_input_port #(.port_number(i)) u_input (
      .io        (io),
      .reset_n   (reset_n),
      .din       (din[i]),
      .frame_n   (frame_n[i]),
      .grant_n   (gnt_col[i][dest[i]]),
      .request_n (req_row[i]),
      .busy_n    (busy_n[i]),
      .dest      (dest[i])
    );

    router_output_arbiter #(.port_number(i)) u_arbiter (
      .io        (io),
      .reset_n   (reset_n),
      .request_n (req_col[i]),
      .frame_n   (src_frame_n[i]),
      .grant_n   (gnt_row[i]),
      .src       (src[i]),
      .deassert  (deassert[i])
    );

    for (genvar j = 0; j < router_frame_pkg::num_ports; j++) begin : g_transpose
      assign req_col[i][j] = req_row[j][i];
      assign gnt_col[i][j] = gnt_row[j][i];
    end
  end

  router_crossbar u_crossbar (
    .io          (io),
    .din         (din),
    .frame_n     (frame_n),
    .valid_n     (valid_n),
    .src         (src),
    .deassert    (deassert),
    .src_frame_n (src_frame_n),
    .dout        (dout),
    .frameo_n    (frameo_n),
    .valido_n    (valido_n)
  );

endmodule

`default_nettype wire

/* rtl/router_arb_pkg.sv */
`default_nettype none

package router_arb_pkg;

  // input sequencer, one state per header bit up to the grant wait
  typedef enum logic [3:0] {
    in_addr0   = 4'd0,
    in_addr1,
    in_addr2,
    in_addr3   = 4'(router_frame_pkg::addr_bits - 1),
    in_pad0    = 4'(router_frame_pkg::addr_bits),
    in_pad1,
    in_request,
    in_wait    = 4'(router_frame_pkg::addr_bits + router_frame_pkg::pad_bits - 1),
    in_forward
  } in_state_t;

  // output arbiter, one-hot
  typedef enum logic [2:0] {
    arb_search = 3'b001,
    arb_grant  = 3'b010,
    arb_hold   = 3'b100
  } arb_state_t;

endpackage

`default_nettype wire

/* rtl/router_crossbar.sv */
`default_nettype none

module router_crossbar (
  input  logic                          io,
  input  router_frame_pkg::port_mask_t  din,
  input  router_frame_pkg::port_mask_t  frame_n,
  input  router_frame_pkg::port_mask_t  valid_n,
  input  router_frame_pkg::port_idx_t   src [router_frame_pkg::num_ports],
  input  router_frame_pkg::port_mask_t  deassert,
  output router_frame_pkg::port_mask_t  src_frame_n,
  output router_frame_pkg::port_mask_t  dout,
  output router_frame_pkg::port_mask_t  frameo_n,
  output router_frame_pkg::port_mask_t  valido_n
);

  router_frame_pkg::port_mask_t din_q;
  router_frame_pkg::port_mask_t frame_q;
  router_frame_pkg::port_mask_t valid_q;

  // one cycle of delay on every input
  always_ff @(posedge io) begin
    din_q   <= din;
    frame_q <= frame_n;
    valid_q <= valid_n;
  end

  always_comb begin
    for (int o = 0; o < router_frame_pkg::num_ports; o++) begin
      src_frame_n[o] = frame_q[src[o]];
      frameo_n[o]    = frame_q[src[o]] | deassert[o];
      valido_n[o]    = valid_q[src[o]] | deassert[o];
      // dout idles at one outside valid bits
      dout[o]        = din_q[src[o]] | valid_q[src[o]] | deassert[o];
    end
  end

endmodule

`default_nettype wire

/* rtl/router_frame_pkg.sv */
`default_nettype none

package router_frame_pkg;

  // every input port has a matching output port
  localparam int num_ports = 16;

  // port index, wide enough to address every port
  typedef logic [$clog2(num_ports)-1:0] port_idx_t;

  // one active-low bit per port
  typedef logic [num_ports-1:0] port_mask_t;

  // header layout on din while frame_n is low
  //   address bits, lsb first
  //   then pad bits of one, valid_n high
  localparam int addr_bits = 4;
  localparam int pad_bits = 4;

endpackage

`default_nettype wire

/* rtl/router_input_port.sv */
`default_nettype none

module router_input_port #(
  parameter int port_number = 0
) (
  input  logic                          io,
  input  logic                          reset_n,
  input  logic                          din,
  input  logic                          frame_n,
  input  logic                          grant_n,
  output router_frame_pkg::port_mask_t  request_n,
  output logic                          busy_n,
  output router_frame_pkg::port_idx_t   dest
);

  router_arb_pkg::in_state_t   state;
  router_arb_pkg::in_state_t   state_next;
  router_frame_pkg::port_idx_t dest_next;
  logic                        busy_next;
  logic                        abort;

  // frame dropped or a pad bit of zero
  assign abort = frame_n | ~din;

  always_ff @(posedge io or negedge reset_n) begin
    if (!reset_n) begin
      state  <= router_arb_pkg::in_addr0;
      dest   <= router_frame_pkg::port_idx_t'(port_number);
      busy_n <= 1'b1;
    end else begin
      state  <= state_next;
      dest   <= dest_next;
      busy_n <= busy_next;
    end
  end

  always_comb begin
    state_next = router_arb_pkg::in_addr0;
    dest_next  = dest;
    busy_next  = 1'b1;
    request_n  = '1;
    case (state)
      router_arb_pkg::in_addr0, router_arb_pkg::in_addr1,
      router_arb_pkg::in_addr2, router_arb_pkg::in_addr3: begin
        // idle is addr0 with frame_n high
        if (!frame_n) begin
          dest_next[state[1:0]] = din;
          state_next = router_arb_pkg::in_state_t'(state + 4'd1);
        end
      end
      router_arb_pkg::in_pad0: begin
        if (!abort) state_next = router_arb_pkg::in_pad1;
      end
      router_arb_pkg::in_pad1: begin
        if (!abort) state_next = router_arb_pkg::in_request;
      end
      router_arb_pkg::in_request: begin
        if (!abort) begin
          request_n[dest] = 1'b0;
          state_next = router_arb_pkg::in_wait;
        end
      end
      router_arb_pkg::in_wait: begin
        // sender keeps padding while busy_n is low
        if (!abort) begin
          if (grant_n) begin
            request_n[dest] = 1'b0;
            busy_next = 1'b0;
            state_next = router_arb_pkg::in_wait;
          end else begin
            state_next = router_arb_pkg::in_forward;
          end
        end
      end
      router_arb_pkg::in_forward: begin
        if (!frame_n) state_next = router_arb_pkg::in_forward;
      end
      default: state_next = router_arb_pkg::in_addr0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/router_output_arbiter.sv */
`default_nettype none

module router_output_arbiter #(
  parameter int port_number = 0
) (
  input  logic                          io,
  input  logic                          reset_n,
  input  router_frame_pkg::port_mask_t  request_n,
  input  logic                          frame_n,
  output router_frame_pkg::port_mask_t  grant_n,
  output router_frame_pkg::port_idx_t   src,
  output logic                          deassert
);

  router_arb_pkg::arb_state_t     state;
  router_arb_pkg::arb_state_t     state_next;
  router_frame_pkg::port_idx_t    last;
  router_frame_pkg::port_idx_t    last_next;
  router_frame_pkg::port_idx_t    pick;
  logic                           hit;
  logic [2*router_frame_pkg::num_ports-1:0] req_twice;
  router_frame_pkg::port_mask_t   req_rot;

  // rotate so that bit 0 is the port just above the last winner
  assign req_twice = {request_n, request_n} >> ({1'b0, last} + 1'b1);
  assign req_rot = req_twice[router_frame_pkg::num_ports-1:0];

  // lowest active requester in rotated order
  always_comb begin
    hit  = 1'b0;
    pick = '0;
    for (int i = router_frame_pkg::num_ports - 1; i >= 0; i--) begin
      if (!req_rot[i]) begin
        hit  = 1'b1;
        pick = router_frame_pkg::port_idx_t'(i);
      end
    end
  end

  always_ff @(posedge io or negedge reset_n) begin
    if (!reset_n) begin
      state <= router_arb_pkg::arb_search;
      last  <= '1;
      // idle mux points at the input of the same number
      src   <= router_frame_pkg::port_idx_t'(port_number);
    end else begin
      state <= state_next;
      last  <= last_next;
      src   <= last_next;
    end
  end

  always_comb begin
    state_next = state;
    last_next  = last;
    grant_n    = '1;
    deassert   = 1'b0;
    case (state)
      router_arb_pkg::arb_search: begin
        deassert = 1'b1;
        if (hit) begin
          last_next  = pick + last + 1'b1;
          state_next = router_arb_pkg::arb_grant;
        end
      end
      router_arb_pkg::arb_grant: begin
        grant_n[last] = 1'b0;
        state_next = router_arb_pkg::arb_hold;
      end
      router_arb_pkg::arb_hold: begin
        // registered frame of the source has ended
        if (frame_n) state_next = router_arb_pkg::arb_search;
      end
      default: state_next = router_arb_pkg::arb_search;
    endcase
  end

endmodule

`default_nettype wire

/* sim/router_tb.sv */
`default_nettype none

module router_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n = router_frame_pkg::num_ports;
  localparam int hdr_bits = router_frame_pkg::addr_bits + router_frame_pkg::pad_bits;
  localparam int depth = 8;
  localparam int limit = 1000;

  logic io = 1'b0;
  logic reset_n;
  router_frame_pkg::port_mask_t din;
  router_frame_pkg::port_mask_t frame_n;
  router_frame_pkg::port_mask_t valid_n;
  wire router_frame_pkg::port_mask_t dout;
  wire router_frame_pkg::port_mask_t frameo_n;
  wire router_frame_pkg::port_mask_t valido_n;
  wire router_frame_pkg::port_mask_t busy_n;

  int seed = 95;
  int mismatches = 0;
  int failures = 0;
  int senders_left = 0;
  string test_name = "reset state";
  logic [hdr_bits-1:0] pkt_hdr [n];
  logic [31:0] pkt_data [n];
  int pkt_len [n];
  logic [31:0] exp_data [n][depth];
  int exp_len [n][depth];
  int exp_wr [n];
  int exp_rd [n];
  int last_win [n];
  logic [n-1:0] saw_busy;
  logic [n-1:0] in_frame;
  logic [31:0] rx_word [n];
  int rx_count [n];
  int rx_port [$];
  logic [31:0] rx_data [$];
  int rx_len [$];

  router router_inst (
    .io       (io),
    .reset_n  (reset_n),
    .din      (din),
    .frame_n  (frame_n),
    .valid_n  (valid_n),
    .dout     (dout),
    .frameo_n (frameo_n),
    .valido_n (valido_n),
    .busy_n   (busy_n)
  );

  always #50 io = ~io;

  // output port taken from the first header bits, lsb first
  function automatic int route_port(input logic [hdr_bits-1:0] header);
    int idx;
    idx = 0;
    for (int b = 0; b < router_frame_pkg::addr_bits; b++) begin
      if (header[b]) idx += 1 << b;
    end
    return idx;
  endfunction

  function automatic logic [31:0] payload_bits(input logic [31:0] data, input int len);
    return data & ((32'd1 << len) - 32'd1);
  endfunction

  // first requester above the last winner, wrapping past the top port
  function automatic int rr_winner(input int last, input logic [n-1:0] req);
    int idx;
    for (int k = 1; k <= n; k++) begin
      idx = (last + k) % n;
      if (req[idx]) return idx;
    end
    return -1;
  endfunction

  function automatic logic [n-1:0] port_bit(input int idx);
    return {{(n-1){1'b0}}, 1'b1} << idx;
  endfunction

  function automatic logic drained();
    if (senders_left != 0 || rx_port.size() != 0 || in_frame != '0) return 1'b0;
    for (int o = 0; o < n; o++) begin
      if (exp_rd[o] != exp_wr[o]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic give_up(input string why);
    $display("ERROR: %s", why);
    failures++;
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("Checks failed");
    $finish;
  endtask

  task automatic prepare(input int src, input int dest);
    pkt_hdr[src] = {{router_frame_pkg::pad_bits{1'b1}}, router_frame_pkg::port_idx_t'(dest)};
    pkt_data[src] = $random(seed);
    pkt_len[src] = 8 + {$random(seed)} % 17;
  endtask

  task automatic expect_from(input int src);
    int port;
    int slot;
    port = route_port(pkt_hdr[src]);
    slot = exp_wr[port] % depth;
    exp_data[port][slot] = payload_bits(pkt_data[src], pkt_len[src]);
    exp_len[port][slot] = pkt_len[src];
    exp_wr[port]++;
    last_win[port] = src;
  endtask

  task automatic end_frame(input int port);
    frame_n[port] = 1'b1;
    din[port] = 1'b1;
    valid_n[port] = 1'b1;
  endtask

  task automatic send_packet(input int port);
    int stall;
    for (int b = 0; b < hdr_bits; b++) begin
      @(negedge io);
      frame_n[port] = 1'b0;
      din[port] = pkt_hdr[port][b];
    end
    for (int b = 0; b < pkt_len[port]; b++) begin
      @(negedge io);
      stall = 0;
      // keep padding while the addressed output is taken
      while (!busy_n[port] && stall < limit) begin
        saw_busy[port] = 1'b1;
        din[port] = 1'b1;
        valid_n[port] = 1'b1;
        @(negedge io);
        stall++;
      end
      if (stall >= limit) give_up($sformatf("timeout: input %0d stuck on busy_n", port));
      din[port] = pkt_data[port][b];
      valid_n[port] = 1'b0;
    end
    @(negedge io);
    end_frame(port);
  endtask

  task automatic send_aborted(input int port, input int nbits);
    for (int b = 0; b < nbits; b++) begin
      @(negedge io);
      frame_n[port] = 1'b0;
      din[port] = pkt_hdr[port][b];
    end
    @(negedge io);
    end_frame(port);
  endtask

  task automatic launch(input logic [n-1:0] senders);
    int cycles;
    for (int i = 0; i < n; i++) begin
      if (senders[i]) begin
        senders_left++;
        fork
          automatic int k = i;
          begin
            send_packet(k);
            senders_left--;
          end
        join_none
      end
    end
    cycles = 0;
    while (!drained() && cycles < limit) begin
      @(negedge io);
      cycles++;
    end
    if (cycles >= limit) give_up($sformatf("timeout: packets of %s never delivered", test_name));
  endtask

  task automatic contend(input int a, input int b, input int dest);
    int first;
    int second;
    first = rr_winner(last_win[dest], port_bit(a) | port_bit(b));
    second = (first == a) ? b : a;
    prepare(a, dest);
    prepare(b, dest);
    expect_from(first);
    expect_from(second);
    saw_busy = '0;
    launch(port_bit(a) | port_bit(b));
    assert (!saw_busy[first] && saw_busy[second]) else begin
      $display("MISMATCH %s: busy_n seen on inputs %0d,%0d expected 01 actual %b%b",
               test_name, first, second, saw_busy[first], saw_busy[second]);
      mismatches++;
    end
  endtask

  task automatic check_packet(input int port, input logic [31:0] data, input int len);
    int slot;
    slot = exp_rd[port] % depth;
    assert (exp_rd[port] != exp_wr[port]) else begin
      $display("ERROR %s: output %0d delivered a packet that nobody sent to it", test_name, port);
      failures++;
    end
    if (exp_rd[port] != exp_wr[port]) begin
      assert (len == exp_len[port][slot]) else begin
        $display("MISMATCH %s: output %0d length expected %0d actual %0d",
                 test_name, port, exp_len[port][slot], len);
        mismatches++;
      end
      assert (data == exp_data[port][slot]) else begin
        $display("MISMATCH %s: output %0d payload expected %h actual %h",
                 test_name, port, exp_data[port][slot], data);
        mismatches++;
      end
      exp_rd[port]++;
    end
  endtask

  // collect valid bits per output between the fall and the rise of frameo_n
  always @(negedge io) begin
    if (reset_n) begin
      for (int o = 0; o < n; o++) begin
        if (!frameo_n[o]) begin
          if (!in_frame[o]) begin
            rx_word[o] = '0;
            rx_count[o] = 0;
          end
          in_frame[o] = 1'b1;
          if (!valido_n[o]) begin
            rx_word[o][rx_count[o]] = dout[o];
            rx_count[o]++;
          end
        end else if (in_frame[o]) begin
          in_frame[o] = 1'b0;
          rx_port.push_back(o);
          rx_data.push_back(rx_word[o]);
          rx_len.push_back(rx_count[o]);
        end else begin
          assert (valido_n[o] && dout[o]) else begin
            $display("MISMATCH %s: output %0d idle valido_n,dout expected 11 actual %b%b",
                     test_name, o, valido_n[o], dout[o]);
            mismatches++;
          end
        end
      end
    end
  end

  always @(posedge io) begin
    while (rx_port.size() > 0) begin
      check_packet(rx_port.pop_front(), rx_data.pop_front(), rx_len.pop_front());
    end
  end

  initial begin
    reset_n = 1'b0;
    din = '1;
    frame_n = '1;
    valid_n = '1;
    saw_busy = '0;
    in_frame = '0;
    for (int o = 0; o < n; o++) begin
      exp_wr[o] = 0;
      exp_rd[o] = 0;
      last_win[o] = n - 1;
    end
    repeat (16) @(negedge io);
    reset_n = 1'b1;
    @(negedge io);
    assert ({dout, frameo_n, valido_n, busy_n} == '1) else begin
      $display("MISMATCH %s: outputs expected %h actual %h", test_name, {(4*n){1'b1}},
               {dout, frameo_n, valido_n, busy_n});
      mismatches++;
    end

    test_name = "single route";
    prepare(3, 10);
    expect_from(3);
    launch(port_bit(3));

    test_name = "contention";
    contend(2, 9, 5);

    // move the last winner of output 5 back to input 2
    test_name = "round robin";
    prepare(2, 5);
    expect_from(2);
    launch(port_bit(2));
    contend(2, 9, 5);

    test_name = "full permutation";
    for (int i = 0; i < n; i++) begin
      prepare(i, (5 * i + 3) % n);
      expect_from(i);
    end
    launch('1);

    test_name = "aborted header";
    prepare(6, 0);
    send_aborted(6, 2);
    // whole header with frame_n held low, only the zero pad bit stops it
    pkt_hdr[6][router_frame_pkg::addr_bits + 1] = 1'b0;
    send_aborted(6, hdr_bits);
    prepare(6, 12);
    expect_from(6);
    launch(port_bit(6));

    repeat (4) @(negedge io);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
